/* flist.f */
+incdir+logic
logic/cpu_state_pkg.sv
logic/ring_msg_pkg.sv
logic/reset_sequencer.sv
logic/index_compare.sv
logic/token_controller.sv
logic/ring_port_mux.sv
logic/ring_bridge.sv
tests/ring_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ring bridge testbench with Verilator, run it, and grep the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module ring_bridge_tb \
  -o ring_bridge_sim > build.log 2>&1 \
  && ./obj_dir/ring_bridge_sim > sim.log 2>&1
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }

/* tests/ring_bridge_tb.sv */
`timescale 1ns/10ps
`include "bridge_defs.svh"

module ring_bridge_tb
  import cpu_state_pkg::*;
  import ring_msg_pkg::*;
();

  localparam int NUM_ROWS = 39;
  localparam logic [`DATA_W-1:0] OWN_IDX = 32'h0000_0123;
  // watchdog limit in ns
  localparam int TIMEOUT = (NUM_ROWS + 20) * 100 * 2;

  // one cycle of stimulus plus what the bridge shows
  typedef struct packed {
    cpu_state_t st;
    // ring index code: own, below, above, own with top bit flipped
    logic [1:0] ix;
    ring_msg_t  rm;
    ring_msg_t  im;
    // done code: none, read_dn, write_dn, rw_halt
    logic [1:0] dn;
    // next_cpu_q, random bits, zero data, online level in this cycle
    logic [3:0] inf;
    // ring msg in the following cycle
    ring_msg_t  msg;
    index_rel_t rel;
    // next_cpu_e, next_state, dispatcher_q, reset pulses, base check
    logic [4:0] exf;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    // reset steps, index held at own value
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00010},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_RESET, REL_NONE, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00100},
    // thread start, second one with zero data
    '{WAIT_FOR_START, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1100, MSG_START, REL_EQUAL, 5'b11101},
    '{WAIT_FOR_START, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1111, MSG_START, REL_EQUAL, 5'b11101},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0001, MSG_NONE, REL_EQUAL, 5'b10000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_EQUAL, 5'b00000},
    // gating while offline
    '{READ_SRC1, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0100, MSG_NONE, REL_EQUAL, 5'b00000},
    '{WRITE_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0100, MSG_NONE, REL_EQUAL, 5'b00000},
    // token taken, then requests pass
    '{READ_COND, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1100, MSG_NONE, REL_EQUAL, 5'b00000},
    '{READ_COND, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    '{WRITE_SRC0, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    '{ALU_BEGIN, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    // read done releases
    '{READ_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd1, 4'b0101, MSG_NONE, REL_EQUAL, 5'b10000},
    '{READ_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    '{WRITE_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0100, MSG_NONE, REL_EQUAL, 5'b00000},
    // write done releases
    '{WRITE_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1100, MSG_NONE, REL_EQUAL, 5'b00000},
    '{WRITE_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd2, 4'b0101, MSG_NONE, REL_EQUAL, 5'b10000},
    '{WRITE_DST, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    // halt releases
    '{READ_SRC0, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1100, MSG_NONE, REL_EQUAL, 5'b00000},
    '{READ_SRC0, 2'd0, MSG_NONE, MSG_NONE, 2'd3, 4'b0101, MSG_NONE, REL_EQUAL, 5'b10000},
    '{READ_SRC0, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0101, MSG_NONE, REL_EQUAL, 5'b00000},
    // fork done in the alu stage
    '{ALU_BEGIN, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b1000, MSG_NONE, REL_EQUAL, 5'b00000},
    '{ALU_BEGIN, 2'd0, MSG_FORK_DONE, MSG_NONE, 2'd0, 4'b0001, MSG_NONE, REL_EQUAL, 5'b10000},
    '{ALU_BEGIN, 2'd0, MSG_FORK_THRD, MSG_NONE, 2'd0, 4'b0001, MSG_NONE, REL_EQUAL, 5'b00000},
    '{ALU_BEGIN, 2'd0, MSG_STOP_DONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_EQUAL, 5'b00000},
    // index relation, top bit only keeps the last
    '{IDLE, 2'd1, MSG_NONE, MSG_NONE, 2'd0, 4'b1000, MSG_NONE, REL_LOWER, 5'b00000},
    '{IDLE, 2'd2, MSG_NONE, MSG_NONE, 2'd0, 4'b1000, MSG_NONE, REL_HIGHER, 5'b00000},
    '{IDLE, 2'd3, MSG_NONE, MSG_NONE, 2'd0, 4'b1000, MSG_NONE, REL_HIGHER, 5'b00000},
    // finish with core message override, then restart
    '{FINISH_BEGIN, 2'd0, MSG_NONE, MSG_FORK_THRD, 2'd0, 4'b1000, MSG_END, REL_EQUAL, 5'b11100},
    '{FINISH_END, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0001, MSG_NONE, REL_EQUAL, 5'b10100},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_EQUAL, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_EQUAL, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_EQUAL, 5'b00010},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_RESET, REL_NONE, 5'b00000},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00100},
    '{IDLE, 2'd0, MSG_NONE, MSG_NONE, 2'd0, 4'b0000, MSG_NONE, REL_NONE, 5'b00000}
  };

  logic         clk = 1'b0;
  logic         ext_rst_b;
  cpu_req_t     cpu;
  ring_msg_t    int_msg_in;
  ring_in_t     ring_in;
  ring_out_t    ring_out;
  ring_msg_t    int_msg_out;
  thread_base_t base;
  logic         cpu_rst;
  logic         bus_busy;
  logic         next_state;
  index_rel_t   index_rel;

  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          cur_row;

  always #50 clk = ~clk;

  ring_bridge u_dut (
    .clk         (clk),
    .ext_rst_b   (ext_rst_b),
    .cpu         (cpu),
    .int_msg_in  (int_msg_in),
    .ring_in     (ring_in),
    .ring_out    (ring_out),
    .int_msg_out (int_msg_out),
    .base        (base),
    .cpu_rst     (cpu_rst),
    .bus_busy    (bus_busy),
    .next_state  (next_state),
    .index_rel   (index_rel)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [`DATA_W-1:0] ring_index_for(input logic [1:0] code);
    case (code)
      2'd1: return OWN_IDX - 32'd5;
      2'd2: return OWN_IDX + 32'h100;
      2'd3: return OWN_IDX | 32'h8000_0000;
      default: return OWN_IDX;
    endcase
  endfunction

  function automatic logic reads_memory(input cpu_state_t st);
    case (st)
      START_READ_CMD, START_READ_CMD_P, READ_COND, READ_COND_P, READ_SRC1,
      READ_SRC1_P, READ_SRC0, READ_SRC0_P, READ_DST, READ_MEM_SIZE_1: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic writes_memory(input cpu_state_t st);
    case (st)
      WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0, WRITE_COND: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // only completion notices go back to the core
  function automatic ring_msg_t filtered_msg(input ring_msg_t m);
    if (m == MSG_FORK_DONE || m == MSG_STOP_DONE) begin
      return m;
    end
    return MSG_NONE;
  endfunction

  // header space skipped, zero data means data follows the code
  function automatic thread_base_t base_rule(input logic [`ADDR_W-1:0] a,
                                             input logic [`DATA_W-1:0] d);
    thread_base_t b;
    logic [`ADDR_W-1:0] hdr;
    hdr = `THREAD_HEADER_SPACE;
    b.base_addr = a + hdr;
    b.base_addr_data = (d == '0) ? a + hdr : d + hdr;
    return b;
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t, row %0d: %s is %b, expected %b", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_msg(input string what, input ring_msg_t got, input ring_msg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t, row %0d: %s is %s, expected %s", $time, cur_row, what,
               got.name(), exp.name());
    end
  endtask

  task automatic check_base(input string what, input thread_base_t got, input thread_base_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t, row %0d: %s is %h, expected %h", $time, cur_row, what, got, exp);
    end
  endtask

  task automatic check_rel(input string what, input index_rel_t got, input index_rel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t, row %0d: %s is %s, expected %s", $time, cur_row, what,
               got.name(), exp.name());
    end
  endtask

  initial begin
    row_t               r;
    row_t               prev;
    cpu_req_t           c;
    ring_in_t           ri;
    logic               rd;
    logic               wr;
    logic [31:0]        bits;
    logic [`ADDR_W-1:0] addr;
    logic [`ADDR_W-1:0] prev_addr;
    logic [`DATA_W-1:0] data;
    logic [`DATA_W-1:0] prev_data;
    ring_msg_t          cur_im;
    lfsr = 16'd13494;
    errors = 0;
    checks = 0;
    cur_row = 0;
    prev = rows[0];
    prev_addr = '0;
    prev_data = '0;
    r = rows[0];
    rd = 1'b0;
    wr = 1'b0;
    ext_rst_b = 1'b1;
    cpu = '0;
    cpu.state = IDLE;
    ring_in = '0;
    ring_in.cpu_index = OWN_IDX;
    int_msg_in = MSG_NONE;
    repeat (5) @(posedge clk);
    for (int i = 0; i <= NUM_ROWS; i++) begin
      cur_row = i;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      data = '0;
      c = '0;
      c.state = IDLE;
      ri = '0;
      ri.cpu_index = OWN_IDX;
      cur_im = MSG_NONE;
      if (i < NUM_ROWS) begin
        r = rows[i];
        if (r.inf[2]) begin
          draw_bits(1, bits);
          rd = bits[0];
          draw_bits(1, bits);
          wr = bits[0];
          draw_bits(`ADDR_W, addr);
          // data stays zero for the data-follows-code case
          if (!r.inf[1]) begin
            draw_bits(`DATA_W, data);
          end
        end
        c = '{state: r.st, read_q: rd, write_q: wr, read_dn: r.dn == 2'd1,
              write_dn: r.dn == 2'd2, rw_halt: r.dn == 2'd3};
        ri = '{next_cpu_q: r.inf[3], cpu_index: ring_index_for(r.ix), msg: r.rm,
               addr: addr, data: data};
        cur_im = r.im;
      end
      ext_rst_b  <= 1'b0;
      cpu        <= c;
      ring_in    <= ri;
      int_msg_in <= cur_im;
      @(negedge clk);
      // registered results of the previous row
      if (i > 0) begin
        check_bit("next_cpu_e", ring_out.next_cpu_e, prev.exf[4]);
        check_bit("next_state", next_state, prev.exf[3]);
        check_bit("dispatcher_q", ring_out.dispatcher_q, prev.exf[2]);
        check_bit("cpu_rst", cpu_rst, prev.exf[1]);
        check_bit("bus_busy", bus_busy, prev.exf[1]);
        check_bit("rst_e", ring_out.rst_e, prev.exf[1]);
        check_rel("index_rel", index_rel, prev.rel);
        if (cur_im == MSG_NONE) begin
          check_msg("ring msg", ring_out.msg, prev.msg);
        end
        if (prev.exf[0]) begin
          check_base("thread base", base, base_rule(prev_addr, prev_data));
        end
      end
      // combinational results of this row
      if (i < NUM_ROWS) begin
        check_bit("read_q", ring_out.read_q, reads_memory(r.st) && r.inf[0] && rd);
        check_bit("write_q", ring_out.write_q, writes_memory(r.st) && r.inf[0] && wr);
        check_msg("int_msg_out", int_msg_out, filtered_msg(r.rm));
        if (r.im != MSG_NONE) begin
          check_msg("core msg override", ring_out.msg, r.im);
        end
      end
      prev = r;
      prev_addr = addr;
      prev_data = data;
      @(posedge clk);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // stop a stuck run
  initial begin
    #(TIMEOUT);
    $display("timeout: the stimulus table did not finish within %0d ns", TIMEOUT);
    $display("Errors found");
    $finish;
  end

endmodule

/* logic/ring_bridge.sv */
`timescale 1ns/10ps

module ring_bridge
  import cpu_state_pkg::*;
  import ring_msg_pkg::*;
(
  input  logic         clk,
  input  logic         ext_rst_b,
  input  cpu_req_t     cpu,
  input  ring_msg_t    int_msg_in,
  input  ring_in_t     ring_in,
  output ring_out_t    ring_out,
  output ring_msg_t    int_msg_out,
  output thread_base_t base,
  output logic         cpu_rst,
  output logic         bus_busy,
  output logic         next_state,
  output index_rel_t   index_rel
);

  // sequencer strobes
  logic      capture_idx;
  logic      run;
  logic      rst_e;
  logic      dispatcher_init;
  ring_msg_t seq_msg;

  // token side
  logic      token_here;
  logic      restart;
  logic      online;
  logic      next_cpu_e;
  logic      dispatcher_q;
  ring_msg_t cmsg;

  // ring side requests and message
  logic      read_q;
  logic      write_q;
  ring_msg_t ring_msg;

  reset_sequencer u_reset_sequencer (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .state           (cpu.state),
    .restart         (restart),
    .capture_idx     (capture_idx),
    .run             (run),
    .cpu_rst         (cpu_rst),
    .bus_busy        (bus_busy),
    .rst_e           (rst_e),
    .dispatcher_init (dispatcher_init),
    .seq_msg         (seq_msg)
  );

  index_compare u_index_compare (
    .clk         (clk),
    .ext_rst_b   (ext_rst_b),
    .capture_idx (capture_idx),
    .cpu_rst     (cpu_rst),
    .ring_idx    (ring_in.cpu_index),
    .next_cpu_q  (ring_in.next_cpu_q),
    .token_here  (token_here),
    .index_rel   (index_rel)
  );

  token_controller u_token_controller (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .run             (run),
    .token_here      (token_here),
    .dispatcher_init (dispatcher_init),
    .seq_msg         (seq_msg),
    .cpu             (cpu),
    .ring_in         (ring_in),
    .next_cpu_e      (next_cpu_e),
    .next_state      (next_state),
    .online          (online),
    .dispatcher_q    (dispatcher_q),
    .restart         (restart),
    .cmsg            (cmsg),
    .base            (base)
  );

  ring_port_mux u_ring_port_mux (
    .cpu         (cpu),
    .online      (online),
    .cmsg        (cmsg),
    .int_msg_in  (int_msg_in),
    .ring_msg_in (ring_in.msg),
    .read_q      (read_q),
    .write_q     (write_q),
    .ring_msg    (ring_msg),
    .int_msg_out (int_msg_out)
  );

  // outgoing ring bundle
  assign ring_out = '{next_cpu_e:   next_cpu_e,
                      dispatcher_q: dispatcher_q,
                      rst_e:        rst_e,
                      read_q:       read_q,
                      write_q:      write_q,
                      msg:          ring_msg};

endmodule

/* logic/ring_port_mux.sv */
`timescale 1ns/10ps

module ring_port_mux
  import cpu_state_pkg::*;
  import ring_msg_pkg::*;
(
  input  cpu_req_t  cpu,
  input  logic      online,
  input  ring_msg_t cmsg,
  input  ring_msg_t int_msg_in,
  input  ring_msg_t ring_msg_in,
  output logic      read_q,
  output logic      write_q,
  output ring_msg_t ring_msg,
  output ring_msg_t int_msg_out
);

  logic rd_state;
  logic wr_state;

  assign rd_state = is_read_state(cpu.state);
  assign wr_state = is_write_state(cpu.state);

  // memory requests only while we own the ring
  assign read_q  = rd_state && online && cpu.read_q;
  assign write_q = wr_state && online && cpu.write_q;

  // core's own fork/stop message wins over bridge message
  assign ring_msg = (int_msg_in != MSG_NONE) ? int_msg_in : cmsg;

  // only completion notices go back into the core
  always_comb begin
    case (ring_msg_in)
      MSG_FORK_DONE, MSG_STOP_DONE: int_msg_out = ring_msg_in;
      default: int_msg_out = MSG_NONE;
    endcase
  end

  // read and write state classes must stay disjoint
  always_comb begin
    assert (!(read_q && write_q))
      else $error("read and write request together");
  end

endmodule

/* logic/token_controller.sv */
`timescale 1ns/10ps
`include "bridge_defs.svh"

module token_controller
  import cpu_state_pkg::*;
  import ring_msg_pkg::*;
(
  input  logic         clk,
  input  logic         ext_rst_b,
  input  logic         run,
  input  logic         token_here,
  input  logic         dispatcher_init,
  input  ring_msg_t    seq_msg,
  input  cpu_req_t     cpu,
  input  ring_in_t     ring_in,
  output logic         next_cpu_e,
  output logic         next_state,
  output logic         online,
  output logic         dispatcher_q,
  output logic         restart,
  output ring_msg_t    cmsg,
  output thread_base_t base
);

  localparam logic [`ADDR_W-1:0] HDR_SPACE = `THREAD_HEADER_SPACE;

  logic rw_state;
  logic rw_release;
  logic alu_done;

  assign rw_state   = is_read_state(cpu.state) || is_write_state(cpu.state);
  // memory cycle over or abandoned
  assign rw_release = cpu.rw_halt || cpu.read_dn || cpu.write_dn;
  // fork or stop finished somewhere on the ring
  assign alu_done   = (ring_in.msg == MSG_FORK_DONE) || (ring_in.msg == MSG_STOP_DONE);

  // finish without the token restarts the reset steps
  assign restart = run && !token_here && (cpu.state == FINISH_END);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      next_cpu_e   <= 1'b0;
      next_state   <= 1'b0;
      online       <= 1'b0;
      dispatcher_q <= 1'b0;
      cmsg         <= MSG_NONE;
      base         <= '0;
    end else if (!run) begin
      // during reset steps the token just passes through
      next_cpu_e   <= token_here;
      next_state   <= 1'b0;
      online       <= 1'b0;
      dispatcher_q <= dispatcher_init;
      cmsg         <= seq_msg;
    end else if (token_here) begin
      online     <= 1'b1;
      next_state <= 1'b0;
      cmsg       <= MSG_NONE;
      next_cpu_e <= 1'b0;
      case (cpu.state)
        WAIT_FOR_START: begin
          cmsg                <= MSG_START;
          base.base_addr      <= ring_in.addr + HDR_SPACE;
          // zero data pointer means data follows the code
          base.base_addr_data <= (ring_in.data == '0) ? ring_in.addr + HDR_SPACE
                                                      : ring_in.data + HDR_SPACE;
          next_cpu_e          <= 1'b1;
          next_state          <= 1'b1;
        end
        FINISH_BEGIN: begin
          cmsg         <= MSG_END;
          dispatcher_q <= 1'b1;
          next_cpu_e   <= 1'b1;
          next_state   <= 1'b1;
        end
        FINISH_END: next_cpu_e <= 1'b1;
        // memory states keep the token until done
        default: next_cpu_e <= 1'b0;
      endcase
    end else begin
      next_state <= 1'b0;
      cmsg       <= MSG_NONE;
      // token went out last cycle
      if (next_cpu_e) begin
        online <= 1'b0;
      end
      if (rw_state) begin
        next_cpu_e <= online && rw_release;
      end else begin
        case (cpu.state)
          ALU_BEGIN: next_cpu_e <= online && alu_done;
          FINISH_BEGIN, FINISH_END: next_cpu_e <= online;
          default: begin
            dispatcher_q <= 1'b0;
            next_cpu_e   <= online;
          end
        endcase
      end
    end
  end

  // core advances only right after the ring offered the token
  a_next_state_after_token : assert property (@(posedge clk) disable iff (ext_rst_b)
    next_state |-> $past(ring_in.next_cpu_q))
    else $error("next_state without the ring token");

endmodule

/* logic/index_compare.sv */
`timescale 1ns/10ps
`include "bridge_defs.svh"

module index_compare
  import ring_msg_pkg::*;
(
  input  logic               clk,
  input  logic               ext_rst_b,
  input  logic               capture_idx,
  input  logic               cpu_rst,
  input  logic [`DATA_W-1:0] ring_idx,
  input  logic               next_cpu_q,
  output logic               token_here,
  output index_rel_t         index_rel
);

  logic [`DATA_W-1:0]      own_idx;
  logic [`IDX_ORDER_MSB:0] ring_ord;
  logic [`IDX_ORDER_MSB:0] own_ord;

  // own index, taken from the ring during reset
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_idx <= '0;
    end else if (capture_idx) begin
      own_idx <= ring_idx;
    end
  end

  // order compares ignore the top bit
  assign ring_ord = ring_idx[`IDX_ORDER_MSB:0];
  assign own_ord  = own_idx[`IDX_ORDER_MSB:0];

  always_ff @(posedge clk) begin
    if (ext_rst_b || cpu_rst) begin
      index_rel <= REL_NONE;
    end else if (next_cpu_q) begin
      if (ring_ord < own_ord) begin
        index_rel <= REL_LOWER;
      end else if (ring_ord > own_ord) begin
        index_rel <= REL_HIGHER;
      end else if (ring_idx == own_idx) begin
        index_rel <= REL_EQUAL;
      end
      // same order but top bit differs, keep last
    end
  end

  // token is ours while the ring points at our full index
  assign token_here = next_cpu_q && (ring_idx == own_idx);

endmodule

/* logic/reset_sequencer.sv */
`timescale 1ns/10ps
`include "bridge_defs.svh"

module reset_sequencer
  import cpu_state_pkg::*;
  import ring_msg_pkg::*;
(
  input  logic       clk,
  input  logic       ext_rst_b,
  input  cpu_state_t state,
  input  logic       restart,
  output logic       capture_idx,
  output logic       run,
  output logic       cpu_rst,
  output logic       bus_busy,
  output logic       rst_e,
  output logic       dispatcher_init,
  output ring_msg_t  seq_msg
);

  // step numbers
  localparam logic [`RST_STEP_W-1:0] STEP_WAIT     = 1;
  localparam logic [`RST_STEP_W-1:0] STEP_DECIDE   = 2;
  localparam logic [`RST_STEP_W-1:0] STEP_CAPTURE  = 3;
  localparam logic [`RST_STEP_W-1:0] STEP_PULSE    = 4;
  localparam logic [`RST_STEP_W-1:0] STEP_DISPATCH = 5;
  localparam logic [`RST_STEP_W-1:0] STEP_RUN      = `RST_STEP_RUN;

  logic [`RST_STEP_W-1:0] step;

  always_ff @(posedge clk) begin
    if (ext_rst_b || restart) begin
      step    <= STEP_WAIT;
      seq_msg <= MSG_NONE;
    end else begin
      // reset message lives one cycle only
      seq_msg <= MSG_NONE;
      case (step)
        STEP_WAIT: step <= STEP_DECIDE;
        // index still valid after a finish so no capture
        STEP_DECIDE: step <= (state == FINISH_END) ? STEP_PULSE : STEP_CAPTURE;
        STEP_CAPTURE: begin
          step    <= STEP_PULSE;
          seq_msg <= MSG_RESET;
        end
        STEP_PULSE: step <= STEP_DISPATCH;
        STEP_DISPATCH: step <= STEP_RUN;
        default: step <= step;
      endcase
    end
  end

  // strobes decoded from the step
  assign capture_idx     = (step == STEP_CAPTURE);
  assign cpu_rst         = (step == STEP_PULSE);
  assign bus_busy        = (step == STEP_PULSE);
  // no reset echo to the ring on a finish restart
  assign rst_e           = (step == STEP_PULSE) && (state != FINISH_END);
  assign dispatcher_init = (step == STEP_DISPATCH);
  assign run             = (step == STEP_RUN);

  // ring echo only with the core reset right after an index capture
  a_rst_e_with_cpu_rst : assert property (@(posedge clk) disable iff (ext_rst_b)
    rst_e |-> cpu_rst && $past(capture_idx))
    else $error("reset echo without index capture and core reset");

endmodule

/* logic/ring_msg_pkg.sv */
`include "bridge_defs.svh"

package ring_msg_pkg;

  // messages carried on the ring
  typedef enum logic [`MSG_W-1:0] {
    MSG_NONE      = 0,
    MSG_RESET,
    MSG_START,
    MSG_END,
    MSG_FORK_THRD,
    MSG_STOP_THRD,
    MSG_FORK_DONE,
    MSG_STOP_DONE
  } ring_msg_t;

  // what the ring presents to this core
  typedef struct packed {
    logic                next_cpu_q;
    logic [`DATA_W-1:0]  cpu_index;
    ring_msg_t           msg;
    logic [`ADDR_W-1:0]  addr;
    logic [`DATA_W-1:0]  data;
  } ring_in_t;

  // what this core presents to the ring
  typedef struct packed {
    logic      next_cpu_e;
    logic      dispatcher_q;
    logic      rst_e;
    logic      read_q;
    logic      write_q;
    ring_msg_t msg;
  } ring_out_t;

  // thread code and data bases, header already skipped
  typedef struct packed {
    logic [`ADDR_W-1:0] base_addr;
    logic [`ADDR_W-1:0] base_addr_data;
  } thread_base_t;

  // ring index against own index
  typedef enum logic [1:0] {
    REL_NONE   = 0,
    REL_LOWER  = 1,
    REL_HIGHER = 2,
    REL_EQUAL  = 3
  } index_rel_t;

endpackage

/* logic/cpu_state_pkg.sv */
`include "bridge_defs.svh"

package cpu_state_pkg;

  // core sequencer states as seen by the bridge
  typedef enum logic [`STATE_W-1:0] {
    WAIT_FOR_START, START_READ_CMD, START_READ_CMD_P,
    READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P,
    READ_SRC0, READ_SRC0_P, READ_DST, READ_MEM_SIZE_1,
    ALU_BEGIN, WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
    WRITE_SRC1, WRITE_SRC0, WRITE_COND,
    FINISH_BEGIN, FINISH_END, IDLE
  } cpu_state_t;

  // states that fetch from ring memory
  function automatic logic is_read_state(input cpu_state_t state);
    return state inside {START_READ_CMD, START_READ_CMD_P, READ_COND, READ_COND_P,
                         READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P,
                         READ_DST, READ_MEM_SIZE_1};
  endfunction

  // states that store to ring memory
  function automatic logic is_write_state(input cpu_state_t state);
    return state inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
                         WRITE_SRC1, WRITE_SRC0, WRITE_COND};
  endfunction

  // core side request and completion levels
  typedef struct packed {
    cpu_state_t state;
    logic       read_q;
    logic       write_q;
    logic       read_dn;
    logic       write_dn;
    logic       rw_halt;
  } cpu_req_t;

endpackage

/* logic/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32

// ring message code width
`define MSG_W 4

// core sequencer state width
`define STATE_W 6

// words reserved ahead of a thread body
`define THREAD_HEADER_SPACE 4

// index order field, top bit kept apart
`define IDX_ORDER_MSB 30

// post-reset step counter
`define RST_STEP_W 3
`define RST_STEP_RUN 7

`endif
